//--- Makefile
# Verilator build and run for the NES core wrapper testbench

SHELL := /bin/bash

VERILATOR ?= verilator
TOP       ?= tb_pocket_nes_core
FLIST     ?= pocket_nes_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- core_settings_if.sv
/*
  Decoded core settings. One writer (the bridge decoder) and any
  number of readers; all fields are registered by the writer.
*/
`timescale 1ns/1ps
`default_nettype none

interface core_settings_if;

  logic                      hide_overscan;
  nes_shell_pkg::mask_edges_t mask_vid_edges;
  logic                      allow_extra_sprites;
  nes_shell_pkg::palette_t   selected_palette;
  logic                      multitap_enabled;
  logic                      map_y_b;

  modport writer (
    output hide_overscan,
    output mask_vid_edges,
    output allow_extra_sprites,
    output selected_palette,
    output multitap_enabled,
    output map_y_b
  );

  modport reader (
    input hide_overscan,
    input mask_vid_edges,
    input allow_extra_sprites,
    input selected_palette,
    input multitap_enabled,
    input map_y_b
  );

endinterface

`default_nettype wire

//--- nes_shell_pkg.sv
/*
  Shared types and constants for the NES shell around the host bridge.
  Bridge addresses are word addresses of the settings block; anything
  outside this list is ignored by the decoder.
*/
`default_nettype none

package nes_shell_pkg;

  //////////////////////////////////////////////////
  // bridge

  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;

  localparam bridge_addr_t ADDR_RESET         = 32'h0000_0050;
  localparam bridge_addr_t ADDR_HIDE_OVERSCAN = 32'h0000_0200;
  localparam bridge_addr_t ADDR_MASK_EDGES    = 32'h0000_0204;
  localparam bridge_addr_t ADDR_EXTRA_SPRITES = 32'h0000_0208;
  localparam bridge_addr_t ADDR_PALETTE       = 32'h0000_020C;
  localparam bridge_addr_t ADDR_MULTITAP      = 32'h0000_0300;
  localparam bridge_addr_t ADDR_MAP_Y_B       = 32'h0000_0310;

  //////////////////////////////////////////////////
  // controllers and pads

  typedef logic [15:0] cont_key_t;

  // bit positions in the key bitmap
  localparam int KEY_UP     = 0;
  localparam int KEY_DOWN   = 1;
  localparam int KEY_LEFT   = 2;
  localparam int KEY_RIGHT  = 3;
  localparam int KEY_FACE_A = 4;
  localparam int KEY_FACE_B = 5;
  localparam int KEY_FACE_Y = 7;
  localparam int KEY_SELECT = 14;
  localparam int KEY_START  = 15;

  // one byte per player, a in the top bit
  typedef struct packed {
    logic a;
    logic b;
    logic select;
    logic start;
    logic up;
    logic down;
    logic left;
    logic right;
  } nes_pad_t;

  localparam int NUM_PLAYERS = 4;

  //////////////////////////////////////////////////
  // settings, video and reset

  typedef logic [1:0] mask_edges_t;
  typedef logic [2:0] palette_t;

  typedef logic [23:0] rgb_t;

  // overscan flag position in the end-of-line slot word
  localparam int SLOT_OVERSCAN_BIT = 13;
  localparam int HS_DELAY_CYCLES   = 7;
  localparam int HS_DELAY_W        = 3;

  localparam int RESET_HOLD_CYCLES = 32'h0010_0000;

endpackage

`default_nettype wire

//--- pad_mapper.sv
/*
  Maps the controller key bitmaps onto NES pads, one register stage.
  Y/B remap applies to player 1 only. Pads 3 and 4 read as zero
  unless the multitap is enabled.
*/
`timescale 1ns/1ps
`default_nettype none

module pad_mapper (
  input  wire                          clk_74a,
  input  wire                          pll_core_locked,
  input  wire nes_shell_pkg::cont_key_t cont1_key,
  input  wire nes_shell_pkg::cont_key_t cont2_key,
  input  wire nes_shell_pkg::cont_key_t cont3_key,
  input  wire nes_shell_pkg::cont_key_t cont4_key,
  core_settings_if.reader              settings,
  output nes_shell_pkg::nes_pad_t      pad1,
  output nes_shell_pkg::nes_pad_t      pad2,
  output nes_shell_pkg::nes_pad_t      pad3,
  output nes_shell_pkg::nes_pad_t      pad4
);

  // plain mapping, face A to a and face B to b
  function automatic nes_shell_pkg::nes_pad_t map_keys(input nes_shell_pkg::cont_key_t key);
    nes_shell_pkg::nes_pad_t pad;
    pad.a      = key[nes_shell_pkg::KEY_FACE_A];
    pad.b      = key[nes_shell_pkg::KEY_FACE_B];
    pad.select = key[nes_shell_pkg::KEY_SELECT];
    pad.start  = key[nes_shell_pkg::KEY_START];
    pad.up     = key[nes_shell_pkg::KEY_UP];
    pad.down   = key[nes_shell_pkg::KEY_DOWN];
    pad.left   = key[nes_shell_pkg::KEY_LEFT];
    pad.right  = key[nes_shell_pkg::KEY_RIGHT];
    return pad;
  endfunction

  nes_shell_pkg::nes_pad_t p1_next;

  // remap shifts a and b one face button over
  always_comb begin
    p1_next = map_keys(cont1_key);
    if (settings.map_y_b) begin
      p1_next.a = cont1_key[nes_shell_pkg::KEY_FACE_B];
      p1_next.b = cont1_key[nes_shell_pkg::KEY_FACE_Y];
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      pad1 <= '0;
      pad2 <= '0;
      pad3 <= '0;
      pad4 <= '0;
    end else begin
      pad1 <= p1_next;
      pad2 <= map_keys(cont2_key);
      pad3 <= settings.multitap_enabled ? map_keys(cont3_key) : '0;
      pad4 <= settings.multitap_enabled ? map_keys(cont4_key) : '0;
    end
  end

endmodule

`default_nettype wire

//--- pocket_nes_core.f
nes_shell_pkg.sv
core_settings_if.sv
settings_regs.sv
reset_stretcher.sv
pad_mapper.sv
video_output_shaper.sv
pocket_nes_core.sv
tb_pocket_nes_core.sv

//--- pocket_nes_core.sv
/*
  Core wrapper between the host bridge and the NES, clk_74a only.
  Bridge is write-only here. Video inputs must be synchronous to
  clk_74a. reset_hold_cycles must be positive.
*/
`timescale 1ns/1ps
`default_nettype none

module pocket_nes_core #(
  parameter int reset_hold_cycles = nes_shell_pkg::RESET_HOLD_CYCLES
) (
  input  wire                           clk_74a,
  input  wire                           pll_core_locked,

  // bridge, write side only
  input  wire nes_shell_pkg::bridge_addr_t bridge_addr,
  input  wire                           bridge_wr,
  input  wire nes_shell_pkg::bridge_data_t bridge_wr_data,

  input  wire nes_shell_pkg::cont_key_t  cont1_key,
  input  wire nes_shell_pkg::cont_key_t  cont2_key,
  input  wire nes_shell_pkg::cont_key_t  cont3_key,
  input  wire nes_shell_pkg::cont_key_t  cont4_key,

  // video from the NES
  input  wire                           h_blank,
  input  wire                           v_blank,
  input  wire                           hsync_in,
  input  wire                           vsync_in,
  input  wire nes_shell_pkg::rgb_t       pixel_rgb,

  output wire                           external_reset,
  output wire nes_shell_pkg::nes_pad_t   pad1,
  output wire nes_shell_pkg::nes_pad_t   pad2,
  output wire nes_shell_pkg::nes_pad_t   pad3,
  output wire nes_shell_pkg::nes_pad_t   pad4,
  output wire                           hide_overscan,
  output wire nes_shell_pkg::mask_edges_t mask_vid_edges,
  output wire                           allow_extra_sprites,
  output wire nes_shell_pkg::palette_t   selected_palette,

  // scaler side
  output wire nes_shell_pkg::rgb_t       video_rgb,
  output wire                           video_de,
  output wire                           video_hs,
  output wire                           video_vs
);

  core_settings_if settings ();

  wire reset_request;

  // settings seen by the NES core
  assign hide_overscan       = settings.hide_overscan;
  assign mask_vid_edges      = settings.mask_vid_edges;
  assign allow_extra_sprites = settings.allow_extra_sprites;
  assign selected_palette    = settings.selected_palette;

  settings_regs i_settings_regs (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .settings       (settings.writer),
    .reset_request  (reset_request)
  );

  reset_stretcher #(
    .hold_cycles(reset_hold_cycles)
  ) i_reset_stretcher (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .reset_request  (reset_request),
    .external_reset (external_reset)
  );

  pad_mapper i_pad_mapper (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .cont1_key      (cont1_key),
    .cont2_key      (cont2_key),
    .cont3_key      (cont3_key),
    .cont4_key      (cont4_key),
    .settings       (settings.reader),
    .pad1           (pad1),
    .pad2           (pad2),
    .pad3           (pad3),
    .pad4           (pad4)
  );

  video_output_shaper i_video_output_shaper (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .h_blank        (h_blank),
    .v_blank        (v_blank),
    .hsync_in       (hsync_in),
    .vsync_in       (vsync_in),
    .pixel_rgb      (pixel_rgb),
    .settings       (settings.reader),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs)
  );

endmodule

`default_nettype wire

//--- reset_stretcher.sv
/*
  Holds external_reset high for hold_cycles clocks after a request.
  A request during the hold restarts the count. hold_cycles must be
  positive.
*/
`timescale 1ns/1ps
`default_nettype none

module reset_stretcher #(
  parameter int hold_cycles = nes_shell_pkg::RESET_HOLD_CYCLES
) (
  input  wire  clk_74a,
  input  wire  pll_core_locked,
  input  wire  reset_request,
  output logic external_reset
);

  localparam int cnt_w = $clog2(hold_cycles + 1);

  logic [cnt_w-1:0] hold_count;

  // load on request, otherwise count down to zero
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_count <= '0;
    end else if (reset_request) begin
      hold_count <= cnt_w'(hold_cycles);
    end else if (hold_count != '0) begin
      hold_count <= hold_count - 1'b1;
    end
  end

  assign external_reset = (hold_count != '0);

  // counter stays within its load value
  assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    hold_count <= cnt_w'(hold_cycles)
  );

endmodule

`default_nettype wire

//--- settings_regs.sv
/*
  Bridge write decoder for the core settings. Every cycle with
  bridge_wr high is a write; there is no stall and no read path.
  Only the low bits of the write data are kept.
*/
`timescale 1ns/1ps
`default_nettype none

module settings_regs (
  input  wire                         clk_74a,
  input  wire                         pll_core_locked,
  input  wire nes_shell_pkg::bridge_addr_t bridge_addr,
  input  wire                         bridge_wr,
  input  wire nes_shell_pkg::bridge_data_t bridge_wr_data,
  core_settings_if.writer             settings,
  output logic                        reset_request
);

  //////////////////////////////////////////////////
  // settings registers

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings.hide_overscan       <= 1'b0;
      settings.mask_vid_edges      <= '0;
      settings.allow_extra_sprites <= 1'b0;
      settings.selected_palette    <= '0;
      settings.multitap_enabled    <= 1'b0;
      settings.map_y_b             <= 1'b0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        nes_shell_pkg::ADDR_HIDE_OVERSCAN: begin
          settings.hide_overscan <= bridge_wr_data[0];
        end
        nes_shell_pkg::ADDR_MASK_EDGES: begin
          settings.mask_vid_edges <= bridge_wr_data[1:0];
        end
        nes_shell_pkg::ADDR_EXTRA_SPRITES: begin
          settings.allow_extra_sprites <= bridge_wr_data[0];
        end
        nes_shell_pkg::ADDR_PALETTE: begin
          settings.selected_palette <= bridge_wr_data[2:0];
        end
        nes_shell_pkg::ADDR_MULTITAP: begin
          settings.multitap_enabled <= bridge_wr_data[0];
        end
        nes_shell_pkg::ADDR_MAP_Y_B: begin
          settings.map_y_b <= bridge_wr_data[0];
        end
        default: begin
          // unlisted address, nothing to update
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // reset request

  // one-cycle pulse, data word is don't care
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      reset_request <= 1'b0;
    end else begin
      reset_request <= bridge_wr && (bridge_addr == nes_shell_pkg::ADDR_RESET);
    end
  end

endmodule

`default_nettype wire

//--- tb_pocket_nes_core.sv
/*
  Testbench for the NES core wrapper, run with a 40-cycle reset hold.
  A reference model on the rising edge tracks every output and expects
  it one edge later. Video inputs are driven on the same clock.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_pocket_nes_core;

  localparam int RESET_HOLD   = 40;
  localparam int HS_LAG       = 7;
  localparam int PAD_CYCLES   = 20;
  localparam int VIDEO_CYCLES = 60;
  // cycle budget of each test, summed for the run limit
  localparam int T1_CYCLES    = 70;
  localparam int T2_CYCLES    = 2 * RESET_HOLD + 40;
  localparam int T3_CYCLES    = 4 * (PAD_CYCLES + 4);
  localparam int T4_CYCLES    = 2 * (VIDEO_CYCLES + 3);
  localparam int T5_CYCLES    = 110;
  localparam int CYCLE_LIMIT  = 8 + T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES
                                + T5_CYCLES + 200;

  logic clk_74a;
  logic pll_core_locked;
  nes_shell_pkg::bridge_addr_t bridge_addr;
  logic bridge_wr;
  nes_shell_pkg::bridge_data_t bridge_wr_data;
  nes_shell_pkg::cont_key_t cont1_key, cont2_key, cont3_key, cont4_key;
  logic h_blank, v_blank, hsync_in, vsync_in;
  nes_shell_pkg::rgb_t pixel_rgb;
  logic external_reset;
  nes_shell_pkg::nes_pad_t pad1, pad2, pad3, pad4;
  logic hide_overscan;
  nes_shell_pkg::mask_edges_t mask_vid_edges;
  logic allow_extra_sprites;
  nes_shell_pkg::palette_t selected_palette;
  nes_shell_pkg::rgb_t video_rgb;
  logic video_de, video_hs, video_vs;

  int value_errors = 0;
  int other_errors = 0;
  int cycle_count = 0;

  pocket_nes_core #(.reset_hold_cycles(RESET_HOLD)) i_dut (.*);

  always #50 clk_74a = ~clk_74a;

  //////////////////////////////////////////////////
  // reference functions

  function automatic nes_shell_pkg::nes_pad_t expected_pad(
    input nes_shell_pkg::cont_key_t key, input int player, input bit remap, input bit multitap
  );
    nes_shell_pkg::nes_pad_t p;
    p.a      = key[nes_shell_pkg::KEY_FACE_A];
    p.b      = key[nes_shell_pkg::KEY_FACE_B];
    p.select = key[nes_shell_pkg::KEY_SELECT];
    p.start  = key[nes_shell_pkg::KEY_START];
    p.up     = key[nes_shell_pkg::KEY_UP];
    p.down   = key[nes_shell_pkg::KEY_DOWN];
    p.left   = key[nes_shell_pkg::KEY_LEFT];
    p.right  = key[nes_shell_pkg::KEY_RIGHT];
    if (player == 1 && remap) begin
      p.a = key[nes_shell_pkg::KEY_FACE_B];
      p.b = key[nes_shell_pkg::KEY_FACE_Y];
    end
    if (player >= 3 && !multitap) begin
      p = '0;
    end
    return p;
  endfunction

  function automatic nes_shell_pkg::rgb_t expected_slot(input bit hide);
    nes_shell_pkg::rgb_t s;
    s = '0;
    s[nes_shell_pkg::SLOT_OVERSCAN_BIT] = hide;
    return s;
  endfunction

  function automatic bit expected_de(input bit hb, input bit vb);
    return !hb && !vb;
  endfunction

  //////////////////////////////////////////////////
  // compare tasks

  task automatic check_bit(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %0d ns %s: got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_pad(
    input string name, input nes_shell_pkg::nes_pad_t got, input nes_shell_pkg::nes_pad_t exp
  );
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %0d ns %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_rgb(
    input string name, input nes_shell_pkg::rgb_t got, input nes_shell_pkg::rgb_t exp
  );
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %0d ns %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_mask_edges(
    input string name, input nes_shell_pkg::mask_edges_t got,
    input nes_shell_pkg::mask_edges_t exp
  );
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %0d ns %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_palette(
    input string name, input nes_shell_pkg::palette_t got, input nes_shell_pkg::palette_t exp
  );
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %0d ns %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // reference model and comparing process

  nes_shell_pkg::nes_pad_t exp_pad [4];
  nes_shell_pkg::mask_edges_t exp_mask;
  nes_shell_pkg::palette_t exp_palette;
  nes_shell_pkg::rgb_t exp_rgb;
  bit exp_hide, exp_sprites, exp_multitap, exp_map_y_b;
  bit exp_de, exp_hs, exp_vs, exp_ext_reset;
  bit prev_de, prev_hs, prev_vs, req_pending;
  int reset_left, edge_idx, last_hs_rise;

  initial begin
    edge_idx = 0;
    last_hs_rise = -100;
  end

  // outputs seen at this edge were set by the previous one
  always @(posedge clk_74a) begin
    edge_idx++;
    if (edge_idx > 1) begin
      check_bit("external_reset", external_reset, exp_ext_reset);
      check_pad("pad1", pad1, exp_pad[0]);
      check_pad("pad2", pad2, exp_pad[1]);
      check_pad("pad3", pad3, exp_pad[2]);
      check_pad("pad4", pad4, exp_pad[3]);
      check_bit("hide_overscan", hide_overscan, exp_hide);
      check_mask_edges("mask_vid_edges", mask_vid_edges, exp_mask);
      check_bit("allow_extra_sprites", allow_extra_sprites, exp_sprites);
      check_palette("selected_palette", selected_palette, exp_palette);
      check_rgb("video_rgb", video_rgb, exp_rgb);
      check_bit("video_de", video_de, exp_de);
      check_bit("video_hs", video_hs, exp_hs);
      check_bit("video_vs", video_vs, exp_vs);
    end
    if (!pll_core_locked) begin
      for (int i = 0; i < 4; i++) exp_pad[i] = '0;
      {exp_hide, exp_sprites, exp_multitap, exp_map_y_b} = '0;
      {exp_de, exp_hs, exp_vs, exp_ext_reset, prev_de, prev_hs, prev_vs, req_pending} = '0;
      exp_mask = '0;
      exp_palette = '0;
      exp_rgb = '0;
      reset_left = 0;
    end else begin
      // pads use the settings held before this edge
      exp_pad[0] = expected_pad(cont1_key, 1, exp_map_y_b, exp_multitap);
      exp_pad[1] = expected_pad(cont2_key, 2, exp_map_y_b, exp_multitap);
      exp_pad[2] = expected_pad(cont3_key, 3, exp_map_y_b, exp_multitap);
      exp_pad[3] = expected_pad(cont4_key, 4, exp_map_y_b, exp_multitap);
      exp_de = expected_de(h_blank, v_blank);
      exp_rgb = exp_de ? pixel_rgb : (prev_de ? expected_slot(exp_hide) : '0);
      prev_de = exp_de;
      exp_vs = vsync_in && !prev_vs;
      prev_vs = vsync_in;
      exp_hs = (edge_idx - last_hs_rise) == HS_LAG;
      if (hsync_in && !prev_hs) last_hs_rise = edge_idx;
      prev_hs = hsync_in;
      // reset goes high one edge after the write is sampled
      if (req_pending) reset_left = RESET_HOLD;
      else if (reset_left > 0) reset_left--;
      exp_ext_reset = reset_left != 0;
      req_pending = bridge_wr && (bridge_addr == nes_shell_pkg::ADDR_RESET);
      if (bridge_wr) begin
        case (bridge_addr)
          nes_shell_pkg::ADDR_HIDE_OVERSCAN: exp_hide     = bridge_wr_data[0];
          nes_shell_pkg::ADDR_MASK_EDGES:    exp_mask     = bridge_wr_data[1:0];
          nes_shell_pkg::ADDR_EXTRA_SPRITES: exp_sprites  = bridge_wr_data[0];
          nes_shell_pkg::ADDR_PALETTE:       exp_palette  = bridge_wr_data[2:0];
          nes_shell_pkg::ADDR_MULTITAP:      exp_multitap = bridge_wr_data[0];
          nes_shell_pkg::ADDR_MAP_Y_B:       exp_map_y_b  = bridge_wr_data[0];
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus helpers

  task automatic bus_write(
    input nes_shell_pkg::bridge_addr_t addr, input nes_shell_pkg::bridge_data_t data
  );
    @(negedge clk_74a);
    bridge_addr = addr;
    bridge_wr_data = data;
    bridge_wr = 1'b1;
    @(negedge clk_74a);
    bridge_wr = 1'b0;
  endtask

  // waits for the reset pulse to rise and then to end
  task automatic wait_reset_pulse();
    int waited;
    waited = 0;
    while (!external_reset && waited < 4) begin
      @(negedge clk_74a);
      waited++;
    end
    if (!external_reset) begin
      other_errors++;
      $display("external_reset did not rise after a reset write");
      return;
    end
    waited = 0;
    while (external_reset && waited < RESET_HOLD + 10) begin
      @(negedge clk_74a);
      waited++;
    end
    if (external_reset) begin
      other_errors++;
      $display("external_reset stayed high past the hold length");
    end
  endtask

  task automatic drive_random_video();
    @(negedge clk_74a);
    h_blank = ($urandom % 4) == 0;
    v_blank = ($urandom % 8) == 0;
    pixel_rgb = 24'($urandom);
  endtask

  //////////////////////////////////////////////////
  // run limit

  always @(posedge clk_74a) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("run stopped at the cycle limit of %0d", CYCLE_LIMIT);
      $display("tests failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // tests

  initial begin
    nes_shell_pkg::bridge_addr_t addrs [6];
    addrs = '{nes_shell_pkg::ADDR_HIDE_OVERSCAN, nes_shell_pkg::ADDR_MASK_EDGES,
              nes_shell_pkg::ADDR_EXTRA_SPRITES, nes_shell_pkg::ADDR_PALETTE,
              nes_shell_pkg::ADDR_MULTITAP, nes_shell_pkg::ADDR_MAP_Y_B};
    void'($urandom(56));
    clk_74a = 1'b0;
    pll_core_locked = 1'b0;
    bridge_addr = '0;
    bridge_wr = 1'b0;
    bridge_wr_data = '0;
    {cont1_key, cont2_key, cont3_key, cont4_key} = '0;
    {h_blank, v_blank, hsync_in, vsync_in} = 4'b1100;
    pixel_rgb = '0;
    repeat (8) @(negedge clk_74a);
    pll_core_locked = 1'b1;

    // settings writes, then addresses outside the map
    repeat (2) @(negedge clk_74a);
    for (int round = 0; round < 4; round++) begin
      for (int i = 0; i < 6; i++) bus_write(addrs[i], $urandom);
    end
    // all settings at zero, so a stray decode shows up
    for (int i = 0; i < 6; i++) bus_write(addrs[i], 32'h0);
    bus_write(32'h0000_0201, 32'hFFFF_FFFF);
    bus_write(32'h0000_1200, 32'hFFFF_FFFF);

    // reset pulse, then a restart during the hold
    bus_write(nes_shell_pkg::ADDR_RESET, $urandom);
    wait_reset_pulse();
    bus_write(nes_shell_pkg::ADDR_RESET, $urandom);
    repeat (15) @(negedge clk_74a);
    bus_write(nes_shell_pkg::ADDR_RESET, $urandom);
    wait_reset_pulse();

    // key mapping for each multitap and remap setting
    for (int combo = 0; combo < 4; combo++) begin
      bus_write(nes_shell_pkg::ADDR_MULTITAP, 32'(combo % 2));
      bus_write(nes_shell_pkg::ADDR_MAP_Y_B, 32'(combo / 2));
      repeat (PAD_CYCLES) begin
        @(negedge clk_74a);
        cont1_key = 16'($urandom);
        cont2_key = 16'($urandom);
        cont3_key = 16'($urandom);
        cont4_key = 16'($urandom);
      end
    end

    // random blanking with both overscan flags
    for (int hide = 0; hide < 2; hide++) begin
      bus_write(nes_shell_pkg::ADDR_HIDE_OVERSCAN, 32'(hide));
      repeat (VIDEO_CYCLES) drive_random_video();
    end

    // sync pulses, spaced and then close together
    @(negedge clk_74a);
    vsync_in = 1'b1;
    repeat (3) @(negedge clk_74a);
    vsync_in = 1'b0;
    for (int line = 0; line < 4; line++) begin
      hsync_in = 1'b1;
      repeat (2) @(negedge clk_74a);
      hsync_in = 1'b0;
      repeat (10) @(negedge clk_74a);
    end
    repeat (30) begin
      @(negedge clk_74a);
      hsync_in = 1'($urandom);
      vsync_in = 1'($urandom);
    end
    hsync_in = 1'b0;
    vsync_in = 1'b0;
    repeat (12) @(negedge clk_74a);

    $display("error counts: %0d value mismatches, %0d other failures",
             value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- video_output_shaper.sv
/*
  Shapes NES video into the scaler format. Inputs are assumed to be
  on clk_74a at one pixel per clock. Hsync is turned into a single
  pulse seven clocks after its rise so it stays clear of vsync.
*/
`timescale 1ns/1ps
`default_nettype none

module video_output_shaper (
  input  wire                      clk_74a,
  input  wire                      pll_core_locked,
  input  wire                      h_blank,
  input  wire                      v_blank,
  input  wire                      hsync_in,
  input  wire                      vsync_in,
  input  wire nes_shell_pkg::rgb_t pixel_rgb,
  core_settings_if.reader          settings,
  output nes_shell_pkg::rgb_t      video_rgb,
  output logic                     video_de,
  output logic                     video_hs,
  output logic                     video_vs
);

  logic                                de;
  logic                                de_prev;
  logic                                hs_prev;
  logic                                vs_prev;
  logic [nes_shell_pkg::HS_DELAY_W-1:0] hs_delay;
  nes_shell_pkg::rgb_t                 slot_word;

  assign de = !(h_blank || v_blank);

  // end-of-line word, only the overscan flag is set
  always_comb begin
    slot_word = '0;
    slot_word[nes_shell_pkg::SLOT_OVERSCAN_BIT] = settings.hide_overscan;
  end

  //////////////////////////////////////////////////
  // data enable and pixels

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_de  <= 1'b0;
      video_rgb <= '0;
      de_prev   <= 1'b0;
    end else begin
      video_de <= de;
      de_prev  <= de;
      if (de) begin
        video_rgb <= pixel_rgb;
      end else if (de_prev) begin
        // first blank cycle after the active area
        video_rgb <= slot_word;
      end else begin
        video_rgb <= '0;
      end
    end
  end

  //////////////////////////////////////////////////
  // sync pulses

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_prev  <= 1'b0;
      vs_prev  <= 1'b0;
      hs_delay <= '0;
      video_hs <= 1'b0;
      video_vs <= 1'b0;
    end else begin
      hs_prev  <= hsync_in;
      vs_prev  <= vsync_in;
      video_vs <= vsync_in && !vs_prev;
      video_hs <= (hs_delay == 1);

      // a new rise restarts the delay
      if (hsync_in && !hs_prev) begin
        hs_delay <= nes_shell_pkg::HS_DELAY_W'(nes_shell_pkg::HS_DELAY_CYCLES);
      end else if (hs_delay != '0) begin
        hs_delay <= hs_delay - 1'b1;
      end
    end
  end

  // sync outputs are single-cycle pulses
  assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    video_vs |=> !video_vs
  );

  assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    video_hs |=> !video_hs
  );

endmodule

`default_nettype wire
